// File: include/board_build.svh
`ifndef BOARD_BUILD_SVH
`define BOARD_BUILD_SVH

// Pick one of the selectors below for BOOT_CONF_SEL to choose where the boot code comes from.
`define BOOT_SEL_STRAPS 0
`define BOOT_SEL_EEPROM 1
`define BOOT_SEL_FAST   2
`define BOOT_CONF_SEL   `BOOT_SEL_STRAPS

`define BOOT_CODE_EEPROM 3'b111
`define BOOT_CODE_FAST   3'b010

`endif

// File: source/board_ctrl_pkg.sv
`default_nettype none

package board_ctrl_pkg;

  localparam int EPB_ADDR_W = 5;
  localparam int DATA_W     = 8;
  localparam int SLOT_W     = 2;
  localparam int IDX_W      = 3;
  localparam int IRQ_W      = 4;  // Interrupt sources handled by the system block.
  localparam int CTRL_W     = 4;  // Writable bits of the misc control register.

  localparam logic [DATA_W-1:0] DESIGN_ID  = 8'hB3;
  localparam logic [DATA_W-1:0] REV_MAJOR  = 8'h01;
  localparam logic [DATA_W-1:0] REV_MINOR  = 8'h04;
  localparam logic [DATA_W-1:0] REV_RCS    = 8'h2A;
  localparam logic [DATA_W-1:0] EMPTY_READ = 8'hFF;  // Read value of an unpopulated slot.

  localparam logic [SLOT_W-1:0] SLOT_MISC = 2'd0;
  localparam logic [SLOT_W-1:0] SLOT_SYS  = 2'd3;

  // Register indexes inside the misc slot.
  localparam logic [IDX_W-1:0] MISC_REG_CONFIG = 3'd0;
  localparam logic [IDX_W-1:0] MISC_REG_DIP    = 3'd1;
  localparam logic [IDX_W-1:0] MISC_REG_CTRL   = 3'd2;
  localparam logic [IDX_W-1:0] MISC_REG_STATUS = 3'd3;

  // Register indexes inside the system slot.
  localparam logic [IDX_W-1:0] SYS_REG_DESIGN_ID = 3'd0;
  localparam logic [IDX_W-1:0] SYS_REG_REV_MAJOR = 3'd1;
  localparam logic [IDX_W-1:0] SYS_REG_REV_MINOR = 3'd2;
  localparam logic [IDX_W-1:0] SYS_REG_REV_RCS   = 3'd3;
  localparam logic [IDX_W-1:0] SYS_REG_IRQ_MASK  = 3'd4;
  localparam logic [IDX_W-1:0] SYS_REG_IRQ_STAT  = 3'd5;

  typedef struct packed {
    logic [SLOT_W-1:0] slot;  // Upper address bits pick one of four slots.
    logic [IDX_W-1:0]  idx;   // Lower bits select a register inside the slot.
  } wb_addr_f_t;

  typedef union packed {
    logic [EPB_ADDR_W-1:0] raw;
    wb_addr_f_t            f;
  } wb_addr_u;

  typedef struct packed {
    logic              stb;
    logic              we;
    wb_addr_u          adr;
    logic [DATA_W-1:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic              ack;
    logic [DATA_W-1:0] dat;
  } wb_rsp_t;

endpackage

`default_nettype wire

// File: source/epb_wb_bridge.sv
`timescale 1ns/100ps
`default_nettype none

module epb_wb_bridge
  import board_ctrl_pkg::*;
(
  input  wire                   clk_master,
  input  wire                   sys_reset,
  input  wire                   epb_cs_n_i,
  input  wire                   epb_we_n_i,
  input  wire                   epb_oe_n_i,
  input  wire  [EPB_ADDR_W-1:0] epb_addr_i,
  input  wire  [DATA_W-1:0]     epb_data_i,
  output logic [DATA_W-1:0]     epb_data_o,
  output logic                  epb_data_oe_o,
  output logic                  epb_rdy_o,
  output wb_req_t               wb_req_o,
  input  wire wb_rsp_t          wb_rsp_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BUS,
    ST_READY
  } state_t;

  state_t                state_q;
  logic                  stb_q;
  logic                  rdy_q;
  logic                  oe_q;
  logic                  we_q;
  logic                  rd_q;
  logic [EPB_ADDR_W-1:0] addr_q;
  logic [DATA_W-1:0]     wdat_q;
  logic [DATA_W-1:0]     rdat_q;
  logic                  start;

  assign start = (state_q == ST_IDLE) && !epb_cs_n_i;  // New host cycle accepted.

  always_ff @(posedge clk_master) begin
    if (sys_reset) begin
      state_q <= ST_IDLE;
      stb_q   <= 1'b0;
      rdy_q   <= 1'b0;
      oe_q    <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (!epb_cs_n_i) begin
            state_q <= ST_BUS;  // Strobe goes out one cycle after capture.
          end
        end
        ST_BUS: begin
          oe_q <= rd_q;  // Drive the data pins only for reads.
          if (wb_rsp_i.ack) begin
            stb_q   <= 1'b0;
            rdy_q   <= 1'b1;
            state_q <= ST_READY;
          end else begin
            stb_q <= 1'b1;
          end
        end
        ST_READY: begin
          rdy_q <= 1'b0;  // Ready is a single-cycle pulse.
          oe_q  <= 1'b0;
          if (epb_cs_n_i) begin
            state_q <= ST_IDLE;  // Host has ended its cycle.
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Address, direction and write data are held for the whole bus cycle.
  always_ff @(posedge clk_master) begin
    if (start) begin
      addr_q <= epb_addr_i;
      we_q   <= !epb_we_n_i;
      rd_q   <= !epb_oe_n_i && epb_we_n_i;
      wdat_q <= epb_data_i;
    end
    if (state_q == ST_BUS && wb_rsp_i.ack) begin
      rdat_q <= wb_rsp_i.dat;  // Read data stays on the pins through ready.
    end
  end

  always_comb begin
    wb_req_o         = '0;
    wb_req_o.stb     = stb_q;
    wb_req_o.we      = we_q;
    wb_req_o.adr.raw = addr_q;
    wb_req_o.dat     = wdat_q;
  end

  assign epb_data_o    = rdat_q;
  assign epb_data_oe_o = oe_q;
  assign epb_rdy_o     = rdy_q;

endmodule

`default_nettype wire

// File: source/wb_slot_decode.sv
`timescale 1ns/100ps
`default_nettype none

module wb_slot_decode
  import board_ctrl_pkg::*;
(
  input  wire          clk_master,
  input  wire          sys_reset,
  input  wire wb_req_t wb_req_i,
  output wb_rsp_t      wb_rsp_o,
  output wb_req_t      misc_req_o,
  output wb_req_t      sys_req_o,
  input  wire wb_rsp_t misc_rsp_i,
  input  wire wb_rsp_t sys_rsp_i
);

  logic [SLOT_W-1:0] slot;
  logic              slot_empty;
  logic              empty_ack_q;

  assign slot       = wb_req_i.adr.f.slot;
  assign slot_empty = (slot != SLOT_MISC) && (slot != SLOT_SYS);  // Slots 1 and 2.

  always_comb begin
    misc_req_o     = wb_req_i;
    misc_req_o.stb = wb_req_i.stb && (slot == SLOT_MISC);
    sys_req_o      = wb_req_i;
    sys_req_o.stb  = wb_req_i.stb && (slot == SLOT_SYS);
  end

  // Stand-in responder so the host never hangs on an unpopulated slot.
  always_ff @(posedge clk_master) begin
    if (sys_reset) begin
      empty_ack_q <= 1'b0;
    end else begin
      empty_ack_q <= wb_req_i.stb && slot_empty && !empty_ack_q;
    end
  end

  always_comb begin
    wb_rsp_o.ack = misc_rsp_i.ack | sys_rsp_i.ack | empty_ack_q;
    case (slot)
      SLOT_MISC: wb_rsp_o.dat = misc_rsp_i.dat;
      SLOT_SYS:  wb_rsp_o.dat = sys_rsp_i.dat;
      default:   wb_rsp_o.dat = EMPTY_READ;
    endcase
  end

endmodule

`default_nettype wire

// File: source/misc_regs.sv
`timescale 1ns/100ps
`default_nettype none

module misc_regs
  import board_ctrl_pkg::*;
(
  input  wire          clk_master,
  input  wire          sys_reset,
  input  wire wb_req_t wb_req_i,
  output wb_rsp_t      wb_rsp_o,
  input  wire  [7:0]   sys_config_i,
  input  wire  [3:0]   user_dip_i,
  input  wire  [3:0]   config_dip_i,
  input  wire          flash_busy_n_i,
  input  wire          mmc_wp_i,
  input  wire          mmc_cdetect_i,
  output logic [1:0]   user_led_n_o,
  output logic         por_force_req_o,
  output logic         geth_reset_req_o
);

  logic              ack_q;
  logic [CTRL_W-1:0] ctrl_q;
  logic [DATA_W-1:0] rdat_q;
  logic [DATA_W-1:0] rd_mux;
  logic              wr_en;

  // Only the first cycle of a strobe is acted upon.
  assign wr_en = wb_req_i.stb && wb_req_i.we && !ack_q;

  always_comb begin
    case (wb_req_i.adr.f.idx)
      MISC_REG_CONFIG: rd_mux = sys_config_i;
      MISC_REG_DIP:    rd_mux = {user_dip_i, config_dip_i};
      MISC_REG_CTRL:   rd_mux = {{(DATA_W - CTRL_W){1'b0}}, ctrl_q};
      MISC_REG_STATUS: rd_mux = {5'b0, mmc_cdetect_i, mmc_wp_i, !flash_busy_n_i};
      default:         rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk_master) begin
    if (sys_reset) begin
      ack_q  <= 1'b0;
      ctrl_q <= '0;  // LEDs off and no reset requests.
    end else begin
      ack_q <= wb_req_i.stb && !ack_q;
      if (wr_en && wb_req_i.adr.f.idx == MISC_REG_CTRL) begin
        ctrl_q <= wb_req_i.dat[CTRL_W-1:0];
      end
    end
  end

  always_ff @(posedge clk_master) begin
    if (wb_req_i.stb && !ack_q) begin
      rdat_q <= rd_mux;
    end
  end

  assign wb_rsp_o.ack     = ack_q;
  assign wb_rsp_o.dat     = rdat_q;
  assign por_force_req_o  = ctrl_q[0];
  assign geth_reset_req_o = ctrl_q[1];
  assign user_led_n_o     = ~ctrl_q[3:2];  // LED pins sink current when lit.

endmodule

`default_nettype wire

// File: source/system_block.sv
`timescale 1ns/100ps
`default_nettype none

module system_block
  import board_ctrl_pkg::*;
(
  input  wire              clk_master,
  input  wire              sys_reset,
  input  wire wb_req_t     wb_req_i,
  output wb_rsp_t          wb_rsp_o,
  input  wire  [IRQ_W-1:0] irq_src_i,
  output logic             irq_o
);

  logic              ack_q;
  logic [DATA_W-1:0] rdat_q;
  logic [DATA_W-1:0] rd_mux;
  logic [IRQ_W-1:0]  mask_q;
  logic [IRQ_W-1:0]  stat_q;
  logic [IRQ_W-1:0]  src_q;
  logic [IRQ_W-1:0]  rise;
  logic [IRQ_W-1:0]  clr;
  logic              irq_q;
  logic              wr_en;

  assign wr_en = wb_req_i.stb && wb_req_i.we && !ack_q;
  assign rise  = irq_src_i & ~src_q;
  assign clr   = (wr_en && wb_req_i.adr.f.idx == SYS_REG_IRQ_STAT) ?
                 wb_req_i.dat[IRQ_W-1:0] : '0;  // Write one to clear.

  always_comb begin
    case (wb_req_i.adr.f.idx)
      SYS_REG_DESIGN_ID: rd_mux = DESIGN_ID;
      SYS_REG_REV_MAJOR: rd_mux = REV_MAJOR;
      SYS_REG_REV_MINOR: rd_mux = REV_MINOR;
      SYS_REG_REV_RCS:   rd_mux = REV_RCS;
      SYS_REG_IRQ_MASK:  rd_mux = {{(DATA_W - IRQ_W){1'b0}}, mask_q};
      SYS_REG_IRQ_STAT:  rd_mux = {{(DATA_W - IRQ_W){1'b0}}, stat_q};
      default:           rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk_master) begin
    if (sys_reset) begin
      ack_q  <= 1'b0;
      mask_q <= '0;
      stat_q <= '0;
      src_q  <= '0;
      irq_q  <= 1'b0;
    end else begin
      ack_q  <= wb_req_i.stb && !ack_q;
      src_q  <= irq_src_i;
      stat_q <= (stat_q & ~clr) | rise;  // A new edge wins over a clear.
      irq_q  <= |(stat_q & mask_q);
      if (wr_en && wb_req_i.adr.f.idx == SYS_REG_IRQ_MASK) begin
        mask_q <= wb_req_i.dat[IRQ_W-1:0];
      end
    end
  end

  always_ff @(posedge clk_master) begin
    if (wb_req_i.stb && !ack_q) begin
      rdat_q <= rd_mux;
    end
  end

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.dat = rdat_q;
  assign irq_o        = irq_q;

endmodule

`default_nettype wire

// File: source/board_reset_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "board_build.svh"

module board_reset_ctrl
  import board_ctrl_pkg::*;
(
  input  wire        clk_master,
  input  wire        sys_reset,
  input  wire        reset_debug_n_i,
  input  wire        por_force_req_i,
  input  wire        geth_reset_req_i,
  input  wire  [3:0] user_dip_i,
  input  wire  [3:0] config_dip_i,
  input  wire  [7:0] sys_config_i,
  output logic       ppc_reset_n_o,
  output logic       ddr2_reset_n_o,
  output logic       geth_reset_n_o,
  output logic       por_force_oe_o,
  output logic       eeprom_wp_o,
  output logic [2:0] boot_conf_o
);

  logic       req_q;
  logic       por_q;
  logic [2:0] strap_code;

  assign ppc_reset_n_o  = reset_debug_n_i && !sys_reset;
  assign ddr2_reset_n_o = !sys_reset;
  assign geth_reset_n_o = !(sys_reset || geth_reset_req_i);
  assign eeprom_wp_o    = !user_dip_i[3];

  // Only a fresh request arms the one-shot force, and only reset releases it.
  always_ff @(posedge clk_master) begin
    if (sys_reset) begin
      req_q <= 1'b0;
      por_q <= 1'b0;
    end else begin
      req_q <= por_force_req_i;
      if (por_force_req_i && !req_q) begin
        por_q <= 1'b1;
      end
    end
  end

  assign por_force_oe_o = por_q;  // Enable pulls the open-drain pin low.

  always_comb begin
    if (!config_dip_i[1]) strap_code = 3'b001;
    else if (!config_dip_i[0]) strap_code = 3'b010;
    else if (sys_config_i[1]) strap_code = `BOOT_CODE_EEPROM;  // I2C boot from EEPROM.
    else strap_code = `BOOT_CODE_FAST;
  end

  always_comb begin
    case (`BOOT_CONF_SEL)
      `BOOT_SEL_EEPROM: boot_conf_o = `BOOT_CODE_EEPROM;
      `BOOT_SEL_FAST:   boot_conf_o = `BOOT_CODE_FAST;
      default:          boot_conf_o = strap_code;
    endcase
  end

endmodule

`default_nettype wire

// File: source/board_ctrl_top.sv
`timescale 1ns/100ps
`default_nettype none

module board_ctrl_top
  import board_ctrl_pkg::*;
(
  input  wire                   clk_master,
  input  wire                   sys_reset,
  input  wire                   epb_cs_n_i,
  input  wire                   epb_we_n_i,
  input  wire                   epb_oe_n_i,
  input  wire  [EPB_ADDR_W-1:0] epb_addr_i,
  input  wire  [DATA_W-1:0]     epb_data_i,
  output logic [DATA_W-1:0]     epb_data_o,
  output logic                  epb_data_oe_o,
  output logic                  epb_rdy_o,
  input  wire  [7:0]            sys_config_i,
  input  wire  [3:0]            user_dip_i,
  input  wire  [3:0]            config_dip_i,
  input  wire                   flash_busy_n_i,
  input  wire                   mmc_wp_i,
  input  wire                   mmc_cdetect_i,
  output logic [1:0]            user_led_n_o,
  input  wire                   reset_debug_n_i,
  output logic                  ppc_reset_n_o,
  output logic                  ddr2_reset_n_o,
  output logic                  geth_reset_n_o,
  output logic                  por_force_oe_o,
  output logic                  eeprom_wp_o,
  output logic [2:0]            boot_conf_o,
  input  wire  [IRQ_W-1:0]      irq_src_i,
  output logic                  irq_o
);

  wb_req_t host_req;
  wb_rsp_t host_rsp;
  wb_req_t misc_req;
  wb_rsp_t misc_rsp;
  wb_req_t sys_req;
  wb_rsp_t sys_rsp;
  logic    por_force_req;
  logic    geth_reset_req;

  epb_wb_bridge u_bridge (
    .clk_master, .sys_reset, .epb_cs_n_i, .epb_we_n_i, .epb_oe_n_i, .epb_addr_i,
    .epb_data_i, .epb_data_o, .epb_data_oe_o, .epb_rdy_o,
    .wb_req_o (host_req),
    .wb_rsp_i (host_rsp)
  );

  wb_slot_decode u_decode (
    .clk_master, .sys_reset,
    .wb_req_i   (host_req),
    .wb_rsp_o   (host_rsp),
    .misc_req_o (misc_req),
    .sys_req_o  (sys_req),
    .misc_rsp_i (misc_rsp),
    .sys_rsp_i  (sys_rsp)
  );

  misc_regs u_misc (
    .clk_master, .sys_reset, .sys_config_i, .user_dip_i, .config_dip_i,
    .flash_busy_n_i, .mmc_wp_i, .mmc_cdetect_i, .user_led_n_o,
    .wb_req_i         (misc_req),
    .wb_rsp_o         (misc_rsp),
    .por_force_req_o  (por_force_req),
    .geth_reset_req_o (geth_reset_req)
  );

  system_block u_system (
    .clk_master, .sys_reset, .irq_src_i, .irq_o,
    .wb_req_i (sys_req),
    .wb_rsp_o (sys_rsp)
  );

  board_reset_ctrl u_reset (
    .clk_master, .sys_reset, .reset_debug_n_i, .user_dip_i, .config_dip_i, .sys_config_i,
    .ppc_reset_n_o, .ddr2_reset_n_o, .geth_reset_n_o, .por_force_oe_o, .eeprom_wp_o,
    .boot_conf_o,
    .por_force_req_i  (por_force_req),
    .geth_reset_req_i (geth_reset_req)
  );

endmodule

`default_nettype wire

// File: tests/board_ctrl_sva.sv
`timescale 1ns/100ps
`default_nettype none

module board_ctrl_sva
  import board_ctrl_pkg::*;
(
  input wire          clk_master,
  input wire          sys_reset,
  input wire wb_req_t req_i,
  input wire wb_rsp_t rsp_i,
  input wire          rdy_i
);

  // Slaves register their ack on the edge after the strobe first appears.
  ack_after_stb: assert property (@(posedge clk_master) disable iff (sys_reset)
    $rose(req_i.stb) |=> rsp_i.ack)
    else $error("ack did not follow the rising strobe by one cycle");

  ack_single: assert property (@(posedge clk_master) disable iff (sys_reset)
    rsp_i.ack |=> !rsp_i.ack)
    else $error("ack stayed high for more than one cycle");

  rdy_single: assert property (@(posedge clk_master) disable iff (sys_reset)
    rdy_i |=> !rdy_i)
    else $error("EPB ready stayed high for more than one cycle");

  // The whole request is frozen while the slave has not answered.
  stb_hold: assert property (@(posedge clk_master) disable iff (sys_reset)
    req_i.stb && !rsp_i.ack |=> req_i.stb && $stable(req_i))
    else $error("request changed or strobe dropped before ack");

endmodule

bind epb_wb_bridge board_ctrl_sva u_sva (
  .clk_master (clk_master),
  .sys_reset  (sys_reset),
  .req_i      (wb_req_o),
  .rsp_i      (wb_rsp_i),
  .rdy_i      (epb_rdy_o)
);

`default_nettype wire

// File: tests/board_ctrl_tb.sv
`timescale 1ns/100ps
`default_nettype none

module board_ctrl_tb
  import board_ctrl_pkg::*;
();

  localparam int BUS_N        = 14;
  localparam int DIRECTED_N   = 6;  // Bus cycles run outside the table.
  localparam int BOOT_N       = 7;
  localparam int RDY_LIMIT    = 8;
  localparam int WATCH_CYCLES = (BUS_N + DIRECTED_N + BOOT_N) * 10 + 200;

  typedef struct packed {
    logic                  wr;
    logic [EPB_ADDR_W-1:0] addr;
    logic [DATA_W-1:0]     data;
    logic [DATA_W-1:0]     exp;
  } bus_op_t;

  typedef struct packed {
    logic [3:0] cdip;
    logic [7:0] scfg;
    logic [2:0] code;
  } boot_case_t;

  // Config DIP, sys_config and the boot code the priority rule gives for them.
  boot_case_t boots [BOOT_N] = '{
    '{4'b0000, 8'h00, 3'b001},
    '{4'b0001, 8'hFF, 3'b001},
    '{4'b0010, 8'hFF, 3'b010},
    '{4'b1110, 8'h00, 3'b010},
    '{4'b0011, 8'h02, 3'b111},
    '{4'b1011, 8'hFD, 3'b010},
    '{4'b1111, 8'hFE, 3'b111}
  };

  logic                  clk_master;
  logic                  sys_reset;
  logic                  epb_cs_n_i;
  logic                  epb_we_n_i;
  logic                  epb_oe_n_i;
  logic [EPB_ADDR_W-1:0] epb_addr_i;
  logic [DATA_W-1:0]     epb_data_i;
  logic [DATA_W-1:0]     epb_data_o;
  logic                  epb_data_oe_o;
  logic                  epb_rdy_o;
  logic [7:0]            sys_config_i;
  logic [3:0]            user_dip_i;
  logic [3:0]            config_dip_i;
  logic                  flash_busy_n_i;
  logic                  mmc_wp_i;
  logic                  mmc_cdetect_i;
  logic [1:0]            user_led_n_o;
  logic                  reset_debug_n_i;
  logic                  ppc_reset_n_o;
  logic                  ddr2_reset_n_o;
  logic                  geth_reset_n_o;
  logic                  por_force_oe_o;
  logic                  eeprom_wp_o;
  logic [2:0]            boot_conf_o;
  logic [IRQ_W-1:0]      irq_src_i;
  logic                  irq_o;

  bus_op_t     ops [BUS_N];
  int          errors = 0;
  integer      seed;
  logic [31:0] rnd;

  board_ctrl_top DUT (.*);

  always #10 clk_master = ~clk_master;

  task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  // Runs one EPB cycle by dropping chip select, waiting for ready and releasing the bus.
  task automatic epb_access(input logic wr, input logic [EPB_ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata);
    int   cycles;
    logic seen;
    @(negedge clk_master);
    epb_cs_n_i = 1'b0;
    epb_we_n_i = !wr;
    epb_oe_n_i = wr;
    epb_addr_i = addr;
    epb_data_i = wdata;
    @(posedge clk_master);  // This edge samples chip select.
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < RDY_LIMIT) begin
      @(negedge clk_master);
      if (epb_rdy_o) begin
        seen = 1'b1;
      end else begin
        cycles++;
      end
    end
    rdata = epb_data_o;
    if (!seen) begin
      $display("No ready from the bridge within %0d cycles, address 0x%h", RDY_LIMIT, addr);
      errors++;
    end else begin
      check_value("epb_rdy_o delay", 8'(cycles), 8'd3);
      check_value("epb_data_oe_o", {7'b0, epb_data_oe_o}, {7'b0, !wr});
    end
    epb_cs_n_i = 1'b1;
    epb_we_n_i = 1'b1;
    epb_oe_n_i = 1'b1;
  endtask

  task automatic apply_op(input logic wr, input logic [EPB_ADDR_W-1:0] addr,
                          input logic [DATA_W-1:0] data, input logic [DATA_W-1:0] exp);
    logic [DATA_W-1:0] rdata;
    epb_access(wr, addr, data, rdata);
    if (!wr) begin
      check_value("epb_data_o", rdata, exp);
    end
  endtask

  task automatic hold_reset(input int cycles);
    sys_reset = 1'b1;
    repeat (cycles) @(negedge clk_master);
    check_value("ddr2_reset_n_o", {7'b0, ddr2_reset_n_o}, 8'h00);
    check_value("ppc_reset_n_o", {7'b0, ppc_reset_n_o}, 8'h00);
    sys_reset = 1'b0;
    @(negedge clk_master);
  endtask

  task automatic check_idle_outputs();
    check_value("epb_rdy_o", {7'b0, epb_rdy_o}, 8'h00);
    check_value("epb_data_oe_o", {7'b0, epb_data_oe_o}, 8'h00);
    check_value("irq_o", {7'b0, irq_o}, 8'h00);
    check_value("por_force_oe_o", {7'b0, por_force_oe_o}, 8'h00);
    check_value("user_led_n_o", {6'b0, user_led_n_o}, 8'h03);  // Both LEDs dark.
    check_value("geth_reset_n_o", {7'b0, geth_reset_n_o}, 8'h01);
    check_value("ddr2_reset_n_o", {7'b0, ddr2_reset_n_o}, 8'h01);
  endtask

  initial begin
    repeat (WATCH_CYCLES) @(posedge clk_master);
    $display("Watchdog expired after %0d cycles, the run did not finish", WATCH_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    clk_master      = 1'b0;
    sys_reset       = 1'b1;
    epb_cs_n_i      = 1'b1;
    epb_we_n_i      = 1'b1;
    epb_oe_n_i      = 1'b1;
    epb_addr_i      = '0;
    epb_data_i      = '0;
    reset_debug_n_i = 1'b1;
    irq_src_i       = '0;
    seed            = 19;
    rnd             = $random(seed);
    sys_config_i    = rnd[7:0];
    user_dip_i      = rnd[11:8];
    config_dip_i    = rnd[15:12];
    flash_busy_n_i  = rnd[16];
    mmc_wp_i        = rnd[17];
    mmc_cdetect_i   = rnd[18];
    hold_reset(5);
    check_idle_outputs();

    ops[0]  = '{1'b0, {2'd3, 3'd0}, 8'h00, DESIGN_ID};
    ops[1]  = '{1'b0, {2'd3, 3'd1}, 8'h00, REV_MAJOR};
    ops[2]  = '{1'b0, {2'd3, 3'd2}, 8'h00, REV_MINOR};
    ops[3]  = '{1'b0, {2'd3, 3'd3}, 8'h00, REV_RCS};
    ops[4]  = '{1'b0, {2'd1, 3'd0}, 8'h00, 8'hFF};  // Empty slots.
    ops[5]  = '{1'b0, {2'd2, 3'd6}, 8'h00, 8'hFF};
    ops[6]  = '{1'b0, {2'd0, 3'd0}, 8'h00, sys_config_i};
    ops[7]  = '{1'b0, {2'd0, 3'd1}, 8'h00, {user_dip_i, config_dip_i}};
    ops[8]  = '{1'b0, {2'd0, 3'd3}, 8'h00, {5'b0, mmc_cdetect_i, mmc_wp_i, !flash_busy_n_i}};
    ops[9]  = '{1'b1, {2'd0, 3'd0}, 8'h5A, 8'h00};
    ops[10] = '{1'b0, {2'd0, 3'd0}, 8'h00, sys_config_i};  // The read-only register kept its value.
    ops[11] = '{1'b1, {2'd0, 3'd2}, 8'h06, 8'h00};
    ops[12] = '{1'b0, {2'd0, 3'd2}, 8'h00, 8'h06};
    ops[13] = '{1'b0, {2'd0, 3'd7}, 8'h00, 8'h00};
    for (int i = 0; i < BUS_N; i++) begin
      apply_op(ops[i].wr, ops[i].addr, ops[i].data, ops[i].exp);
    end
    // Control value 0x06 lights LED 0 and holds the PHY in reset.
    check_value("user_led_n_o", {6'b0, user_led_n_o}, 8'h02);
    check_value("geth_reset_n_o", {7'b0, geth_reset_n_o}, 8'h00);
    check_value("eeprom_wp_o", {7'b0, eeprom_wp_o}, {7'b0, !user_dip_i[3]});

    apply_op(1'b1, {2'd0, 3'd2}, 8'h01, 8'h00);
    @(negedge clk_master);
    check_value("por_force_oe_o", {7'b0, por_force_oe_o}, 8'h01);
    apply_op(1'b1, {2'd0, 3'd2}, 8'h00, 8'h00);
    @(negedge clk_master);
    check_value("por_force_oe_o", {7'b0, por_force_oe_o}, 8'h01);  // Latched until reset.
    hold_reset(5);
    check_idle_outputs();

    @(negedge clk_master);
    irq_src_i = 4'b0001;
    @(negedge clk_master);
    irq_src_i = 4'b0000;
    repeat (3) @(negedge clk_master);
    check_value("irq_o", {7'b0, irq_o}, 8'h00);  // Masked source.
    apply_op(1'b0, {2'd3, 3'd5}, 8'h00, 8'h01);
    apply_op(1'b1, {2'd3, 3'd4}, 8'h01, 8'h00);
    @(negedge clk_master);
    check_value("irq_o", {7'b0, irq_o}, 8'h01);
    apply_op(1'b1, {2'd3, 3'd5}, 8'h01, 8'h00);
    @(negedge clk_master);
    check_value("irq_o", {7'b0, irq_o}, 8'h00);
    apply_op(1'b0, {2'd3, 3'd5}, 8'h00, 8'h00);

    for (int i = 0; i < BOOT_N; i++) begin
      @(negedge clk_master);
      config_dip_i    = boots[i].cdip;
      sys_config_i    = boots[i].scfg;
      reset_debug_n_i = i[0];
      @(negedge clk_master);
      check_value("boot_conf_o", {5'b0, boot_conf_o}, {5'b0, boots[i].code});
      check_value("ppc_reset_n_o", {7'b0, ppc_reset_n_o}, {7'b0, reset_debug_n_i});
    end
    reset_debug_n_i = 1'b1;

    $display("Checks finished with %0d error(s)", errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+include
source/board_ctrl_pkg.sv
source/epb_wb_bridge.sv
source/wb_slot_decode.sv
source/misc_regs.sv
source/system_block.sv
source/board_reset_ctrl.sv
source/board_ctrl_top.sv
tests/board_ctrl_sva.sv
tests/board_ctrl_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the board controller testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
  --timescale 1ns/100ps \
  --top-module board_ctrl_tb \
  -f sources.f \
  -o board_ctrl_sim

./obj_dir/board_ctrl_sim | tee "$LOG"

if grep -q "SIMULATION FAILED" "$LOG"; then
  echo "Testbench reported errors, see $LOG"
  exit 1
fi

echo "Run finished without errors"
